/* csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// datapath widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12

// user-mode counter aliases, read only
`define CSR_ADDR_CYCLE          12'hC00
`define CSR_ADDR_INSTRET        12'hC02
`define CSR_ADDR_CYCLEH         12'hC80
`define CSR_ADDR_INSTRETH       12'hC82

// machine identity
`define CSR_ADDR_MVENDORID      12'hF11
`define CSR_ADDR_MARCHID        12'hF12
`define CSR_ADDR_MIMPID         12'hF13
`define CSR_ADDR_MHARTID        12'hF14

// machine trap setup and handling
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MCOUNTINHIBIT  12'h320
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344

// machine counters
`define CSR_ADDR_MCYCLE         12'hB00
`define CSR_ADDR_MINSTRET       12'hB02
`define CSR_ADDR_MCYCLEH        12'hB80
`define CSR_ADDR_MINSTRETH      12'hB82

// fixed values, MXL = 1 and only the I extension
`define CSR_MISA_VALUE          32'h4000_0100
`define CSR_MIMPID_VALUE        32'h0000_0002
`define CSR_MTVEC_ALIGN         6

`endif

/* csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]   word_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // privilege levels, supervisor is not implemented
    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_e;

    // writable registers, one code per target of the write broadcast
    typedef enum logic [3:0] {
        sel_none,
        sel_mstatus,
        sel_mtvec,
        sel_mie,
        sel_mip,
        sel_mscratch,
        sel_mepc,
        sel_mcause,
        sel_mtval,
        sel_mcycle,
        sel_mcycleh,
        sel_minstret,
        sel_minstreth,
        sel_mcountinhibit
    } csr_sel_e;

    // single-cycle access request
    typedef struct packed {
        logic      valid;
        logic      write;
        csr_addr_t addr;
        word_t     wdata;
    } csr_req_t;

    typedef struct packed {
        word_t rdata;
        logic  illegal;
    } csr_rsp_t;

    // qualified write, en only for legal writable targets
    typedef struct packed {
        logic     en;
        csr_sel_e sel;
        word_t    data;
    } csr_wr_t;

    typedef struct packed {
        logic  valid;
        logic  is_mret;
        word_t epc;
        word_t cause;
        word_t tval;
    } trap_req_t;

    // stored mstatus fields only
    typedef struct packed {
        logic  mprv;
        priv_e mpp;
        logic  mpie;
        logic  mie;
    } mstatus_t;

    typedef struct packed {
        priv_e    priv;
        mstatus_t mstat;
    } mach_state_t;

endpackage

/* csr_access_decode.sv */
`include "csr_defs.svh"

module csr_access_decode #(
    parameter int unsigned hart_id = 0
) (
    input  csr_pkg::csr_req_t    req,
    input  csr_pkg::mach_state_t state,
    input  csr_pkg::word_t       mtvec,
    input  csr_pkg::word_t       mepc,
    input  csr_pkg::word_t       mcause,
    input  csr_pkg::word_t       mtval,
    input  csr_pkg::word_t       mscratch,
    input  csr_pkg::word_t       mip,
    input  csr_pkg::word_t       mie,
    input  logic [63:0]          mcycle,
    input  logic [63:0]          minstret,
    input  logic [2:0]           mcountinhibit,
    output csr_pkg::csr_rsp_t    rsp,
    output csr_pkg::csr_wr_t     wr
);
    import csr_pkg::*;

    word_t    rdata;
    logic     illegal;
    csr_sel_e sel;
    word_t    mstatus_word;

    // mprv at 17, mpp at 12:11, mpie at 7, mie at 3
    assign mstatus_word = {14'b0, state.mstat.mprv, 4'b0, state.mstat.mpp,
                           3'b0, state.mstat.mpie, 3'b0, state.mstat.mie, 3'b0};

    //////////////////////////////
    // address decode, user group first
    //////////////////////////////
    always_comb begin
        rdata   = '0;
        illegal = 1'b0;
        sel     = sel_none;
        case (req.addr)
            `CSR_ADDR_CYCLE:     rdata = mcycle[31:0];
            `CSR_ADDR_CYCLEH:    rdata = mcycle[63:32];
            `CSR_ADDR_INSTRET:   rdata = minstret[31:0];
            `CSR_ADDR_INSTRETH:  rdata = minstret[63:32];
            default:             illegal = 1'b1;
        endcase

        // machine group only reached on a user-group miss
        if (illegal && state.priv == priv_machine) begin
            illegal = 1'b0;
            case (req.addr)
                `CSR_ADDR_MISA:          rdata = `CSR_MISA_VALUE;
                `CSR_ADDR_MVENDORID:     rdata = '0;
                `CSR_ADDR_MARCHID:       rdata = '0;
                `CSR_ADDR_MIMPID:        rdata = `CSR_MIMPID_VALUE;
                `CSR_ADDR_MHARTID:       rdata = word_t'(hart_id);
                `CSR_ADDR_MSTATUS: begin
                    rdata = mstatus_word;
                    sel   = sel_mstatus;
                end
                `CSR_ADDR_MTVEC: begin
                    rdata = mtvec;
                    sel   = sel_mtvec;
                end
                `CSR_ADDR_MIE: begin
                    rdata = mie;
                    sel   = sel_mie;
                end
                `CSR_ADDR_MIP: begin
                    rdata = mip;
                    sel   = sel_mip;
                end
                `CSR_ADDR_MSCRATCH: begin
                    rdata = mscratch;
                    sel   = sel_mscratch;
                end
                `CSR_ADDR_MEPC: begin
                    rdata = mepc;
                    sel   = sel_mepc;
                end
                `CSR_ADDR_MCAUSE: begin
                    rdata = mcause;
                    sel   = sel_mcause;
                end
                `CSR_ADDR_MTVAL: begin
                    rdata = mtval;
                    sel   = sel_mtval;
                end
                `CSR_ADDR_MCYCLE: begin
                    rdata = mcycle[31:0];
                    sel   = sel_mcycle;
                end
                `CSR_ADDR_MCYCLEH: begin
                    rdata = mcycle[63:32];
                    sel   = sel_mcycleh;
                end
                `CSR_ADDR_MINSTRET: begin
                    rdata = minstret[31:0];
                    sel   = sel_minstret;
                end
                `CSR_ADDR_MINSTRETH: begin
                    rdata = minstret[63:32];
                    sel   = sel_minstreth;
                end
                `CSR_ADDR_MCOUNTINHIBIT: begin
                    rdata = {29'b0, mcountinhibit};
                    sel   = sel_mcountinhibit;
                end
                default:                 illegal = 1'b1;
            endcase
        end
    end

    // idle cycles return all zeros
    assign rsp.rdata   = req.valid ? rdata : '0;
    assign rsp.illegal = req.valid & illegal;

    // read-only hits leave sel at sel_none and drop the write
    assign wr.en   = req.valid & req.write & ~illegal & (sel != sel_none);
    assign wr.sel  = sel;
    assign wr.data = req.wdata;

endmodule

/* csr_machine_regs.sv */
`include "csr_defs.svh"

module csr_machine_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_pkg::csr_wr_t     wr,
    input  csr_pkg::trap_req_t   trap,
    output csr_pkg::mach_state_t state,
    output csr_pkg::word_t       mtvec,
    output csr_pkg::word_t       mepc,
    output csr_pkg::word_t       mcause,
    output csr_pkg::word_t       mtval,
    output csr_pkg::word_t       mscratch
);
    import csr_pkg::*;

    localparam logic [1:0] mode_direct   = 2'b00;
    localparam logic [1:0] mode_vectored = 2'b01;
    localparam int         align         = `CSR_MTVEC_ALIGN;

    priv_e    priv;
    mstatus_t mstat;
    word_t    mtvec_wr;

    assign state.priv  = priv;
    assign state.mstat = mstat;

    // legalized mtvec, reserved modes fall back to direct
    always_comb begin
        if (wr.data[1:0] == mode_vectored) begin
            mtvec_wr = {wr.data[`CSR_XLEN-1:align], {(align-2){1'b0}}, mode_vectored};
        end else begin
            mtvec_wr = {wr.data[`CSR_XLEN-1:2], mode_direct};
        end
    end

    //////////////////////////////
    // csr writes, then trap and mret
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv       <= priv_machine;
            mstat.mprv <= 1'b0;
            mstat.mpp  <= priv_user;
            mstat.mpie <= 1'b1;
            mstat.mie  <= 1'b1;
            mtvec      <= '0;
            mepc       <= '0;
            mcause     <= '0;
            mtval      <= '0;
            mscratch   <= '0;
        end else begin
            if (wr.en) begin
                case (wr.sel)
                    sel_mstatus: begin
                        mstat.mprv <= wr.data[17];
                        // only user and machine exist for mpp
                        mstat.mpp  <= (wr.data[12:11] == 2'b11) ? priv_machine : priv_user;
                        mstat.mpie <= wr.data[7];
                        mstat.mie  <= wr.data[3];
                    end
                    sel_mtvec:    mtvec    <= mtvec_wr;
                    sel_mepc:     mepc     <= {wr.data[`CSR_XLEN-1:2], 2'b00};
                    sel_mcause:   mcause   <= wr.data;
                    sel_mtval:    mtval    <= wr.data;
                    sel_mscratch: mscratch <= wr.data;
                    default: begin
                    end
                endcase
            end

            // later assignments take priority over the write above
            if (trap.valid) begin
                if (trap.is_mret) begin
                    priv       <= mstat.mpp;
                    mstat.mie  <= mstat.mpie;
                    mstat.mpie <= 1'b1;
                    mstat.mpp  <= priv_user;
                    if (mstat.mpp != priv_machine) begin
                        mstat.mprv <= 1'b0;
                    end
                end else begin
                    priv       <= priv_machine;
                    mstat.mpie <= mstat.mie;
                    mstat.mie  <= 1'b0;
                    mstat.mpp  <= priv;
                    // 32-bit instruction alignment, low bits never stored
                    mepc       <= {trap.epc[`CSR_XLEN-1:2], 2'b00};
                    mcause     <= trap.cause;
                    mtval      <= trap.tval;
                end
            end
        end
    end

endmodule

/* csr_counters.sv */
module csr_counters (
    input  logic             clk,
    input  logic             rst_n,
    input  csr_pkg::csr_wr_t wr,
    input  logic             retire,
    output logic [63:0]      mcycle,
    output logic [63:0]      minstret,
    output logic [2:0]       mcountinhibit
);
    import csr_pkg::*;

    // bit positions inside mcountinhibit
    localparam int cy = 0;
    localparam int ir = 2;

    //////////////////////////////
    // cycle counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else if (wr.en && wr.sel == sel_mcycle) begin
            mcycle <= {mcycle[63:32], wr.data};
        end else if (wr.en && wr.sel == sel_mcycleh) begin
            mcycle <= {wr.data, mcycle[31:0]};
        end else if (!mcountinhibit[cy]) begin
            mcycle <= mcycle + 64'd1;
        end
    end

    //////////////////////////////
    // retired instruction counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (wr.en && wr.sel == sel_minstret) begin
            minstret <= {minstret[63:32], wr.data};
        end else if (wr.en && wr.sel == sel_minstreth) begin
            minstret <= {wr.data, minstret[31:0]};
        end else if (retire && !mcountinhibit[ir]) begin
            minstret <= minstret + 64'd1;
        end
    end

    // TM has no counter here, so bit 1 stays zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcountinhibit <= '0;
        end else if (wr.en && wr.sel == sel_mcountinhibit) begin
            mcountinhibit <= {wr.data[ir], 1'b0, wr.data[cy]};
        end
    end

endmodule

/* csr_interrupts.sv */
`include "csr_defs.svh"

module csr_interrupts (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_pkg::csr_wr_t     wr,
    input  csr_pkg::mach_state_t state,
    input  logic                 mtime_interrupt,
    input  csr_pkg::word_t       int_sources,
    output csr_pkg::word_t       mip,
    output csr_pkg::word_t       mie,
    output csr_pkg::word_t       interrupts
);
    import csr_pkg::*;

    localparam int mti = 7;

    logic [`CSR_XLEN-1:16] mip_plat;
    logic [`CSR_XLEN-1:16] mie_plat;
    logic                  mie_mti;

    //////////////////////////////
    // pending and enable registers
    //////////////////////////////

    // platform bits are sticky, a write can only clear what is not
    // being asserted in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mip_plat <= '0;
        end else if (wr.en && wr.sel == sel_mip) begin
            mip_plat <= wr.data[`CSR_XLEN-1:16] | int_sources[`CSR_XLEN-1:16];
        end else begin
            mip_plat <= mip_plat | int_sources[`CSR_XLEN-1:16];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_plat <= '0;
            mie_mti  <= 1'b0;
        end else if (wr.en && wr.sel == sel_mie) begin
            mie_plat <= wr.data[`CSR_XLEN-1:16];
            mie_mti  <= wr.data[mti];
        end
    end

    // timer bit follows the input directly
    assign mip = {mip_plat, 8'b0, mtime_interrupt, 7'b0};
    assign mie = {mie_plat, 8'b0, mie_mti, 7'b0};

    //////////////////////////////
    // masking
    //////////////////////////////
    always_comb begin
        if (state.priv == priv_machine) begin
            interrupts = state.mstat.mie ? (mip & mie) : '0;
        end else begin
            // user mode is always interruptible by machine interrupts
            interrupts = mip & mie;
        end
    end

endmodule

/* csr_unit.sv */
module csr_unit #(
    parameter int unsigned hart_id = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::trap_req_t trap,
    input  logic               retire,
    input  logic               mtime_interrupt,
    input  csr_pkg::word_t     int_sources,
    output csr_pkg::csr_rsp_t  rsp,
    output csr_pkg::word_t     mepc,
    output csr_pkg::word_t     mtvec,
    output csr_pkg::word_t     interrupts
);
    import csr_pkg::*;

    csr_wr_t     wr;
    mach_state_t state;
    word_t       mcause;
    word_t       mtval;
    word_t       mscratch;
    word_t       mip;
    word_t       mie;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [2:0]  mcountinhibit;

    // legality, read mux and write broadcast
    csr_access_decode #(
        .hart_id (hart_id)
    ) u_decode (
        .req           (req),
        .state         (state),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval),
        .mscratch      (mscratch),
        .mip           (mip),
        .mie           (mie),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcountinhibit (mcountinhibit),
        .rsp           (rsp),
        .wr            (wr)
    );

    csr_machine_regs u_machine_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .trap     (trap),
        .state    (state),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .mscratch (mscratch)
    );

    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr            (wr),
        .retire        (retire),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .mcountinhibit (mcountinhibit)
    );

    csr_interrupts u_interrupts (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr              (wr),
        .state           (state),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .mip             (mip),
        .mie             (mie),
        .interrupts      (interrupts)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 8 rising edges, released between edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* csr_unit_chk.sv */
module csr_unit_chk (
    input logic              clk,
    input logic              rst_n,
    input csr_pkg::csr_rsp_t rsp,
    input csr_pkg::word_t    mepc,
    input csr_pkg::word_t    mtvec
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;

    // an illegal access never leaks data
    illegal_rdata_zero: assert property (
        @(posedge clk) disable iff (!rst_n) rsp.illegal |-> (rsp.rdata == '0)
    ) else begin
        $error("illegal access returned nonzero read data");
        failures++;
    end

    // mepc always word aligned
    mepc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) mepc[1:0] == 2'b00
    ) else begin
        $error("mepc holds a misaligned address");
        failures++;
    end

    // only direct or vectored mode is ever stored
    mtvec_mode_legal: assert property (
        @(posedge clk) disable iff (!rst_n) !mtvec[1]
    ) else begin
        $error("mtvec holds a reserved mode");
        failures++;
    end

endmodule

bind csr_unit csr_unit_chk u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .rsp   (rsp),
    .mepc  (mepc),
    .mtvec (mtvec)
);

/* csr_unit_tb.sv */
`include "csr_defs.svh"

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int reset_timeout = 100;

    logic        clk;
    logic        rst_n;
    csr_req_t    req;
    trap_req_t   trap;
    logic        retire;
    logic        mtime_interrupt;
    word_t       int_sources;
    csr_rsp_t    rsp;
    word_t       mepc;
    word_t       mtvec;
    word_t       interrupts;

    logic [31:0] lfsr;
    string       current_test;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned assert_failures;
    logic        reset_ok;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_unit #(
        .hart_id (5)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .trap            (trap),
        .retire          (retire),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .rsp             (rsp),
        .mepc            (mepc),
        .mtvec           (mtvec),
        .interrupts      (interrupts)
    );

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // right-shifting galois lfsr
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hD000_0001;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // mprv 17, mpp 12:11, mpie 7, mie 3
    function automatic word_t pack_mstatus(input logic mprv, input logic [1:0] mpp,
                                           input logic mpie, input logic mie);
        word_t w;
        w        = '0;
        w[17]    = mprv;
        w[12:11] = mpp;
        w[7]     = mpie;
        w[3]     = mie;
        return w;
    endfunction

    task automatic check_value(input string item, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
                     current_test, item, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", current_test, test_errors);
        end
    endtask

    task automatic wait_for_reset(output logic released);
        int cycles;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < reset_timeout) begin
            @(posedge clk);
            released = rst_n;
            cycles++;
        end
    endtask

    // one-cycle request sampled in the low phase and cleared at the next falling edge
    task automatic access_csr(input logic write, input csr_addr_t addr, input word_t wdata,
                              output word_t rdata, output logic illegal);
        @(negedge clk);
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        #2;
        rdata   = rsp.rdata;
        illegal = rsp.illegal;
        @(negedge clk);
        req = '0;
    endtask

    task automatic write_csr(input csr_addr_t addr, input word_t wdata);
        word_t rdata;
        logic  illegal;
        access_csr(1'b1, addr, wdata, rdata, illegal);
    endtask

    task automatic read_and_check(input string item, input csr_addr_t addr,
                                  input word_t expected);
        word_t rdata;
        logic  illegal;
        access_csr(1'b0, addr, '0, rdata, illegal);
        check_value({item, " illegal flag"}, 32'd0, 32'(illegal));
        check_value(item, expected, rdata);
    endtask

    task automatic expect_illegal(input string item, input csr_addr_t addr);
        word_t rdata;
        logic  illegal;
        access_csr(1'b0, addr, '0, rdata, illegal);
        check_value({item, " illegal flag"}, 32'd1, 32'(illegal));
        check_value({item, " rdata"}, 32'd0, rdata);
    endtask

    task automatic raise_trap(input logic is_mret, input word_t epc, input word_t cause,
                              input word_t tval);
        @(negedge clk);
        trap.valid   = 1'b1;
        trap.is_mret = is_mret;
        trap.epc     = epc;
        trap.cause   = cause;
        trap.tval    = tval;
        @(negedge clk);
        trap = '0;
    endtask

    task automatic pulse_retire();
        @(negedge clk);
        retire = 1'b1;
        @(negedge clk);
        retire = 1'b0;
    endtask

    task automatic check_interrupts(input string item, input word_t expected);
        @(negedge clk);
        #2;
        check_value(item, expected, interrupts);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic reset_values();
        begin_test("reset_values");
        read_and_check("misa", `CSR_ADDR_MISA, `CSR_MISA_VALUE);
        read_and_check("mimpid", `CSR_ADDR_MIMPID, 32'd2);
        read_and_check("mhartid", `CSR_ADDR_MHARTID, 32'd5);
        read_and_check("mstatus", `CSR_ADDR_MSTATUS, pack_mstatus(1'b0, 2'b00, 1'b1, 1'b1));
        check_interrupts("interrupts", 32'd0);
        expect_illegal("unknown address", 12'h123);
        end_test();
    endtask

    task automatic trap_register_rw();
        word_t d;
        word_t v;
        begin_test("trap_register_rw");
        d = random_bits(32);
        write_csr(`CSR_ADDR_MSCRATCH, d);
        read_and_check("mscratch", `CSR_ADDR_MSCRATCH, d);
        d = random_bits(32);
        write_csr(`CSR_ADDR_MCAUSE, d);
        read_and_check("mcause", `CSR_ADDR_MCAUSE, d);
        d = random_bits(32);
        write_csr(`CSR_ADDR_MTVAL, d);
        read_and_check("mtval", `CSR_ADDR_MTVAL, d);
        d = random_bits(32);
        write_csr(`CSR_ADDR_MEPC, d);
        read_and_check("mepc", `CSR_ADDR_MEPC, {d[31:2], 2'b00});
        check_value("mepc port", {d[31:2], 2'b00}, mepc);

        // vectored mode keeps its mode bits and a 64-byte aligned base
        v = random_bits(30);
        d = {v[29:0], 2'b01};
        write_csr(`CSR_ADDR_MTVEC, d);
        read_and_check("mtvec vectored", `CSR_ADDR_MTVEC, {d[31:6], 6'b000001});
        check_value("mtvec port", {d[31:6], 6'b000001}, mtvec);

        // mode 2 or 3 falls back to direct
        v = random_bits(30);
        d = {v[29:0], 1'b1, lfsr_bit()};
        write_csr(`CSR_ADDR_MTVEC, d);
        read_and_check("mtvec reserved", `CSR_ADDR_MTVEC, {d[31:2], 2'b00});
        end_test();
    endtask

    task automatic trap_and_mret();
        word_t epc;
        word_t cause;
        word_t tval;
        word_t rdata;
        logic  illegal;
        begin_test("trap_and_mret");
        epc   = random_bits(32);
        cause = random_bits(32);
        tval  = random_bits(32);
        raise_trap(1'b0, epc, cause, tval);
        check_value("mepc port", {epc[31:2], 2'b00}, mepc);
        read_and_check("mepc", `CSR_ADDR_MEPC, {epc[31:2], 2'b00});
        read_and_check("mcause", `CSR_ADDR_MCAUSE, cause);
        read_and_check("mtval", `CSR_ADDR_MTVAL, tval);
        read_and_check("mstatus after trap", `CSR_ADDR_MSTATUS,
                       pack_mstatus(1'b0, 2'b11, 1'b1, 1'b0));

        // return to user mode
        write_csr(`CSR_ADDR_MSTATUS, pack_mstatus(1'b0, 2'b00, 1'b1, 1'b0));
        raise_trap(1'b1, '0, '0, '0);
        expect_illegal("mstatus in user mode", `CSR_ADDR_MSTATUS);
        expect_illegal("mscratch in user mode", `CSR_ADDR_MSCRATCH);
        access_csr(1'b0, `CSR_ADDR_CYCLE, '0, rdata, illegal);
        check_value("cycle in user mode", 32'd0, 32'(illegal));

        // trap out of user mode
        raise_trap(1'b0, random_bits(32), random_bits(32), random_bits(32));
        read_and_check("mstatus after second trap", `CSR_ADDR_MSTATUS,
                       pack_mstatus(1'b0, 2'b00, 1'b1, 1'b0));
        write_csr(`CSR_ADDR_MSTATUS, pack_mstatus(1'b0, 2'b00, 1'b1, 1'b1));
        end_test();
    endtask

    task automatic counter_behavior();
        word_t w;
        word_t first;
        logic  illegal;
        int    k;
        int    n;
        begin_test("counter_behavior");
        w = random_bits(32);
        k = int'(random_bits(3)) + 2;
        write_csr(`CSR_ADDR_MCYCLE, w);
        // write_csr returns one cycle after the write cycle
        repeat (k - 2) @(negedge clk);
        access_csr(1'b0, `CSR_ADDR_MCYCLE, '0, first, illegal);
        check_value("mcycle after write", w + 32'(k - 1), first);

        // an inhibited counter keeps the written value
        write_csr(`CSR_ADDR_MCOUNTINHIBIT, 32'h1);
        read_and_check("mcountinhibit", `CSR_ADDR_MCOUNTINHIBIT, 32'h1);
        w = random_bits(32);
        write_csr(`CSR_ADDR_MCYCLE, w);
        read_and_check("mcycle inhibited", `CSR_ADDR_MCYCLE, w);
        repeat (3) @(negedge clk);
        read_and_check("mcycle still inhibited", `CSR_ADDR_MCYCLE, w);
        write_csr(`CSR_ADDR_MCOUNTINHIBIT, 32'h0);

        w = random_bits(32);
        n = int'(random_bits(3)) + 1;
        write_csr(`CSR_ADDR_MINSTRET, w);
        repeat (n) pulse_retire();
        read_and_check("minstret", `CSR_ADDR_MINSTRET, w + 32'(n));
        end_test();
    endtask

    task automatic interrupt_masking();
        begin_test("interrupt_masking");
        @(negedge clk);
        mtime_interrupt = 1'b1;
        write_csr(`CSR_ADDR_MIE, 32'h0000_0080);
        check_interrupts("timer enabled", 32'h0000_0080);
        write_csr(`CSR_ADDR_MSTATUS, pack_mstatus(1'b0, 2'b00, 1'b1, 1'b0));
        check_interrupts("masked by mstatus", 32'd0);
        write_csr(`CSR_ADDR_MSTATUS, pack_mstatus(1'b0, 2'b00, 1'b1, 1'b1));
        @(negedge clk);
        mtime_interrupt = 1'b0;

        // one-cycle pulse on platform source 20
        write_csr(`CSR_ADDR_MIE, 32'h0010_0000);
        @(negedge clk);
        int_sources = 32'h0010_0000;
        @(negedge clk);
        int_sources = '0;
        check_interrupts("platform pending", 32'h0010_0000);
        read_and_check("mip sticky", `CSR_ADDR_MIP, 32'h0010_0000);
        write_csr(`CSR_ADDR_MIP, 32'd0);
        read_and_check("mip cleared", `CSR_ADDR_MIP, 32'd0);
        check_interrupts("platform cleared", 32'd0);
        end_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        req             = '0;
        trap            = '0;
        retire          = 1'b0;
        mtime_interrupt = 1'b0;
        int_sources     = '0;
        lfsr            = 32'h166c9721;
        checks          = 0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;

        wait_for_reset(reset_ok);
        if (!reset_ok) begin
            $display("reset was never released");
            $display("Checks failed");
            $finish;
        end else begin
            reset_values();
            trap_register_rw();
            trap_and_mret();
            counter_behavior();
            interrupt_masking();

            assert_failures = uut.u_chk.failures;
            $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
                     tests_run, tests_failed, checks, errors, assert_failures);
            if (errors == 0 && assert_failures == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+.
csr_pkg.sv
csr_access_decode.sv
csr_machine_regs.sv
csr_counters.sv
csr_interrupts.sv
csr_unit.sv
tb_clock_gen.sv
csr_unit_chk.sv
csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the csr unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module csr_unit_tb -f compile.f \
    && ./obj_dir/Vcsr_unit_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

grep -qx "All checks passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
